//--- hw/forth_config.svh
// core sizing macros
// data width, program address width, data stack depth
`ifndef FORTH_CONFIG_SVH
`define FORTH_CONFIG_SVH

// data path width in bits
`define FORTH_DW 32

// program address width, 256 bytes of program memory
`define FORTH_AW 8

// stack entries below the top of stack
`define FORTH_DS_DEPTH 16

// depth count width, counts 0..17 including tos
`define FORTH_DEPTH_W 5

`endif

//--- hw/forth_pkg.sv
// forth core package
// opcode enumeration and opcode byte union
`default_nettype none

package forth_pkg;

    // operations, low 7 bits of an opcode byte with top bit clear
    typedef enum logic [6:0] {
        NOP   = 7'd0,
        DUP   = 7'd1,
        DROP  = 7'd2,
        OVER  = 7'd3,
        SWAP  = 7'd4,
        ADD   = 7'd5,
        SUB   = 7'd6,
        AND   = 7'd7,
        OR    = 7'd8,
        XOR   = 7'd9,
        ZEQ   = 7'd10,  // 0=
        EQ    = 7'd11,
        LT    = 7'd12,  // signed
        GT    = 7'd13,  // signed
        BRAN  = 7'd14,  // two bytes, target follows
        ZBRAN = 7'd15,  // two bytes, target follows
        HALT  = 7'd16
    } opcode_e;

    // byte read as an operation
    typedef struct packed {
        logic    is_lit;  // clear here
        opcode_e code;
    } op_fmt_t;

    // byte read as a short literal
    typedef struct packed {
        logic       is_lit;  // set here
        logic [6:0] value;   // zero extended on push
    } lit_fmt_t;

    // one program byte, two decodes sharing the top bit
    typedef union packed {
        op_fmt_t    op;
        lit_fmt_t   lit;
        logic [7:0] raw;
    } op_byte_u;

endpackage

`default_nettype wire

//--- hw/stack_if.sv
// exec unit to data stack interface
// push/pop strobes, write data, nos and fill status
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

interface stack_if;

    logic                      push;   // strobe, acted on at the edge
    logic                      pop;    // strobe, push+pop replaces nos
    logic [`FORTH_DW-1:0]      din;    // value pushed below tos
    logic [`FORTH_DW-1:0]      nos;    // entry just below tos
    logic [`FORTH_DEPTH_W-1:0] depth;  // stored entries, tos not counted
    logic                      full;
    logic                      empty;

    // data stack side
    modport buffer (
        input  push, pop, din,
        output nos, depth, full, empty
    );

    // execution unit side
    modport user (
        output push, pop, din,
        input  nos, depth, full, empty
    );

endinterface

`default_nettype wire

//--- hw/fetch_if.sv
// fetch unit to exec unit interface
// opcode presentation and ip step/skip/jump control
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

interface fetch_if;
    import forth_pkg::*;

    op_byte_u              op;      // byte at ip
    logic [7:0]            arg;     // byte at ip+1, branch target
    logic [`FORTH_AW-1:0]  ip;
    logic                  valid;   // core running
    logic                  step;    // one opcode retired
    logic                  skip;    // two-byte opcode retired
    logic                  jump;    // redirect to target
    logic [`FORTH_AW-1:0]  target;
    logic                  stop;    // halt or fault, ends the run

    modport producer (
        output op, arg, ip, valid,
        input  step, skip, jump, target, stop
    );

    modport consumer (
        input  op, arg, ip, valid,
        output step, skip, jump, target, stop
    );

endinterface

`default_nettype wire

//--- hw/fetch_unit.sv
// fetch unit
// program memory with host write port, ip register, run flag
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 prog_we,
    input  logic [`FORTH_AW-1:0] prog_addr,
    input  logic [7:0]           prog_data,
    input  logic                 start,
    fetch_if.producer            fif
);

    localparam int MEM_BYTES = 1 << `FORTH_AW;

    logic [7:0]           prog_mem [0:MEM_BYTES-1];  // opcode bytes
    logic [`FORTH_AW-1:0] arg_addr;                  // ip+1, wraps at the top
    logic                 running;

    // host write, no reset on the array
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    // asynchronous read, op follows ip in the same cycle
    assign arg_addr  = fif.ip + 1'b1;
    assign fif.op    = prog_mem[fif.ip];
    assign fif.arg   = prog_mem[arg_addr];
    assign fif.valid = running;

    // run flag
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (!running) begin
            if (start) begin
                running <= 1'b1;  // start ignored while busy
            end
        end else if (fif.stop) begin
            running <= 1'b0;      // halt or fault retired
        end
    end

    // instruction pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            fif.ip <= '0;
        end else if (!running) begin
            if (start) begin
                fif.ip <= '0;  // every run begins at byte 0
            end
        end else if (fif.step) begin
            if (fif.jump) begin
                fif.ip <= fif.target;       // absolute branch
            end else if (fif.skip) begin
                fif.ip <= fif.ip + 2'd2;    // opcode plus target byte
            end else begin
                fif.ip <= fif.ip + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/data_stack.sv
// data stack below the top of stack
// register array, stack pointer, full/empty flags
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

module data_stack (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    stack_if.buffer sif
);

    localparam int IW = $clog2(`FORTH_DS_DEPTH);  // entry index width

    logic [`FORTH_DW-1:0]      stack_mem [0:`FORTH_DS_DEPTH-1];
    logic [`FORTH_DEPTH_W-1:0] sp;         // entry count, next free slot
    logic [IW-1:0]             top_idx;    // slot holding nos
    logic [IW-1:0]             free_idx;   // slot a push writes

    assign top_idx  = sp[IW-1:0] - 1'b1;
    assign free_idx = sp[IW-1:0];

    // status toward the exec unit
    assign sif.nos   = (sp == '0) ? '0 : stack_mem[top_idx];  // reads 0 when empty
    assign sif.depth = sp;
    assign sif.empty = (sp == '0);
    assign sif.full  = (sp == `FORTH_DEPTH_W'(`FORTH_DS_DEPTH));

    // entry storage, exec never pushes while full
    always_ff @(posedge clk) begin
        if (sif.push && sif.pop) begin
            stack_mem[top_idx] <= sif.din;   // swap, nos replaced in place
        end else if (sif.push) begin
            stack_mem[free_idx] <= sif.din;
        end
    end

    // pointer
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sp <= '0;  // clear empties in one cycle
        end else if (sif.push && !sif.pop) begin
            sp <= sp + 1'b1;
        end else if (sif.pop && !sif.push) begin
            sp <= sp - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
// execution unit
// opcode decode, tos register, alu, compares, branches, halt and fault
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

module exec_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    fetch_if.consumer                 fif,
    stack_if.user                     sif,
    output logic [`FORTH_DW-1:0]      tos,
    output logic [`FORTH_DEPTH_W-1:0] depth,
    output logic                      done,
    output logic                      fault
);
    import forth_pkg::*;

    localparam logic [`FORTH_DW-1:0] TRUE_W = '1;  // forth true

    op_byte_u                  op;
    logic                      tos_v;      // tos slot holds a value
    logic [`FORTH_DW-1:0]      tos_nx;
    logic                      tos_v_nx;
    logic [`FORTH_DEPTH_W-1:0] need;       // operands required
    logic                      grow;       // opcode adds an item
    logic                      push_c;
    logic                      pop_c;
    logic                      jump_c;
    logic                      skip_c;
    logic                      halt_c;
    logic                      bad;        // underflow or overflow
    logic                      new_run;

    assign op      = fif.op;
    assign new_run = start && !fif.valid;
    assign depth   = sif.depth + {{(`FORTH_DEPTH_W-1){1'b0}}, tos_v};

    // decode, one opcode per valid cycle
    always_comb begin
        need     = '0;
        grow     = 1'b0;
        push_c   = 1'b0;
        pop_c    = 1'b0;
        jump_c   = 1'b0;
        skip_c   = 1'b0;
        halt_c   = 1'b0;
        tos_nx   = tos;
        tos_v_nx = tos_v;
        if (op.lit.is_lit) begin
            grow     = 1'b1;
            push_c   = tos_v;  // old tos moves down only if present
            tos_nx   = {{(`FORTH_DW-7){1'b0}}, op.lit.value};
            tos_v_nx = 1'b1;
        end else begin
            case (op.op.code)
                DUP: begin
                    need   = 'd1;
                    grow   = 1'b1;
                    push_c = 1'b1;
                end
                DROP: begin
                    need     = 'd1;
                    pop_c    = !sif.empty;
                    tos_nx   = sif.nos;     // 0 once the stack is gone
                    tos_v_nx = !sif.empty;
                end
                OVER: begin
                    need   = 'd2;
                    grow   = 1'b1;
                    push_c = 1'b1;
                    tos_nx = sif.nos;
                end
                SWAP: begin
                    need   = 'd2;
                    push_c = 1'b1;  // push+pop rewrites nos
                    pop_c  = 1'b1;
                    tos_nx = sif.nos;
                end
                ADD, SUB, AND, OR, XOR, EQ, LT, GT: begin
                    need  = 'd2;
                    pop_c = 1'b1;
                    case (op.op.code)
                        ADD:     tos_nx = sif.nos + tos;
                        SUB:     tos_nx = sif.nos - tos;  // n1 n2 -- n1-n2
                        AND:     tos_nx = sif.nos & tos;
                        OR:      tos_nx = sif.nos | tos;
                        XOR:     tos_nx = sif.nos ^ tos;
                        EQ:      tos_nx = (sif.nos == tos) ? TRUE_W : '0;
                        LT:      tos_nx = ($signed(sif.nos) < $signed(tos)) ? TRUE_W : '0;
                        default: tos_nx = ($signed(sif.nos) > $signed(tos)) ? TRUE_W : '0;
                    endcase
                end
                ZEQ: begin
                    need   = 'd1;
                    tos_nx = (tos == '0) ? TRUE_W : '0;
                end
                BRAN: begin
                    skip_c = 1'b1;
                    jump_c = 1'b1;
                end
                ZBRAN: begin
                    need     = 'd1;
                    skip_c   = 1'b1;          // fall through past target byte
                    jump_c   = (tos == '0);
                    pop_c    = !sif.empty;    // flag consumed
                    tos_nx   = sif.nos;
                    tos_v_nx = !sif.empty;
                end
                HALT:    halt_c = 1'b1;
                default: ;                    // NOP and unused codes
            endcase
        end
        bad = (depth < need) || (grow && sif.full && tos_v);  // full below a live tos
    end

    // stack strobes, suppressed on a fault so the stack stays put
    assign sif.push = fif.valid && !bad && push_c;
    assign sif.pop  = fif.valid && !bad && pop_c;
    assign sif.din  = tos;

    // fetch control
    assign fif.step   = fif.valid;
    assign fif.skip   = fif.valid && skip_c;
    assign fif.jump   = fif.valid && !bad && jump_c;
    assign fif.target = fif.arg[`FORTH_AW-1:0];
    assign fif.stop   = fif.valid && (bad || halt_c);

    // tos register, run status
    always_ff @(posedge clk) begin
        if (rst) begin
            tos   <= '0;
            tos_v <= 1'b0;
            fault <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;  // single-cycle pulse
            if (new_run) begin
                tos   <= '0;
                tos_v <= 1'b0;
                fault <= 1'b0;  // sticky until the next start
            end else if (fif.valid) begin
                if (bad) begin
                    fault <= 1'b1;  // tos and depth kept
                    done  <= 1'b1;
                end else begin
                    tos   <= tos_nx;
                    tos_v <= tos_v_nx;
                    done  <= halt_c;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/forth_core.sv
// forth core top level
// fetch unit, data stack and exec unit behind plain ports
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

module forth_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prog_we,
    input  logic [`FORTH_AW-1:0]      prog_addr,
    input  logic [7:0]                prog_data,
    input  logic                      start,
    output logic [`FORTH_DW-1:0]      tos,
    output logic [`FORTH_DEPTH_W-1:0] depth,
    output logic                      busy,
    output logic                      done,
    output logic                      fault
);

    fetch_if fif ();
    stack_if sif ();

    logic stack_clear;  // start accepted only while idle

    assign busy        = fif.valid;
    assign stack_clear = start && !fif.valid;

    fetch_unit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .fif       (fif.producer)
    );

    data_stack u_stack (
        .clk   (clk),
        .rst   (rst),
        .clear (stack_clear),
        .sif   (sif.buffer)
    );

    exec_unit u_exec (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .fif   (fif.consumer),
        .sif   (sif.user),
        .tos   (tos),
        .depth (depth),
        .done  (done),
        .fault (fault)
    );

endmodule

`default_nettype wire

//--- testbench/tb_forth_model.svh
// reference interpreter for the forth core
// program image and builder tasks for literal, op and branch bytes

logic [7:0] prog [0:(1 << `FORTH_AW) - 1];  // mirrored into core memory
int         prog_len;

task automatic new_program();
    prog_len = 0;
endtask

task automatic emit(logic [7:0] value);
    prog[prog_len] = value;
    prog_len++;
endtask

// short literal, top bit set
task automatic emit_lit(logic [6:0] value);
    op_byte_u b;
    b.lit.is_lit = 1'b1;
    b.lit.value  = value;
    emit(b.raw);
endtask

task automatic emit_op(opcode_e code);
    op_byte_u b;
    b.op.is_lit = 1'b0;
    b.op.code   = code;
    emit(b.raw);
endtask

// opcode then absolute target byte
task automatic emit_branch(opcode_e code, logic [7:0] target);
    emit_op(code);
    emit(target);
endtask

// items a word takes from the stack
function automatic int needs(op_byte_u b);
    if (b.lit.is_lit) return 0;
    case (b.op.code)
        DUP, DROP, ZEQ, ZBRAN: return 1;
        OVER, SWAP, ADD, SUB, AND, OR, XOR, EQ, LT, GT: return 2;
        default: return 0;  // nop, halt, bran
    endcase
endfunction

// second item op top item, flags all ones or zero
function automatic logic [`FORTH_DW-1:0] alu_ref(opcode_e code,
                                                 logic [`FORTH_DW-1:0] a,
                                                 logic [`FORTH_DW-1:0] t);
    case (code)
        ADD:     return a + t;
        SUB:     return a - t;
        AND:     return a & t;
        OR:      return a | t;
        XOR:     return a ^ t;
        EQ:      return {`FORTH_DW{a == t}};
        LT:      return {`FORTH_DW{$signed(a) < $signed(t)}};
        default: return {`FORTH_DW{$signed(a) > $signed(t)}};
    endcase
endfunction

// walk prog[] from byte 0 until halt or fault
function automatic void ref_run(output logic [`FORTH_DW-1:0]      r_tos,
                                output logic [`FORTH_DEPTH_W-1:0] r_depth,
                                output logic                      r_fault,
                                output int                        r_steps);
    logic [`FORTH_DW-1:0] stk [0:`FORTH_DS_DEPTH];  // tos sits at n-1
    logic [`FORTH_DW-1:0] t;
    logic [`FORTH_DW-1:0] a;
    logic [7:0]           ip;
    logic [7:0]           nxt;
    op_byte_u             b;
    int                   n;
    int                   steps;
    bit                   grow;
    bit                   halted;
    n       = 0;
    ip      = '0;
    steps   = 0;
    halted  = 1'b0;
    r_fault = 1'b0;
    while (!halted && steps < 4096) begin
        b    = prog[ip];
        grow = b.lit.is_lit || b.op.code == DUP || b.op.code == OVER;
        steps++;
        if (n < needs(b) || (grow && n == `FORTH_DS_DEPTH + 1)) begin
            r_fault = 1'b1;  // stack untouched
            halted  = 1'b1;
        end else if (b.lit.is_lit) begin
            stk[n] = {{(`FORTH_DW-7){1'b0}}, b.lit.value};
            n++;
            ip++;
        end else begin
            t   = (n > 0) ? stk[n-1] : '0;
            a   = (n > 1) ? stk[n-2] : '0;
            nxt = ip + 8'd1;
            case (b.op.code)
                DUP: begin
                    stk[n] = t;
                    n++;
                end
                DROP: n--;
                OVER: begin
                    stk[n] = a;
                    n++;
                end
                SWAP: begin
                    stk[n-1] = a;
                    stk[n-2] = t;
                end
                ADD, SUB, AND, OR, XOR, EQ, LT, GT: begin
                    stk[n-2] = alu_ref(b.op.code, a, t);
                    n--;
                end
                ZEQ:  stk[n-1] = {`FORTH_DW{t == '0}};
                BRAN: nxt = prog[ip + 8'd1];
                ZBRAN: begin
                    n--;  // flag consumed either way
                    nxt = (t == '0) ? prog[ip + 8'd1] : ip + 8'd2;
                end
                HALT:    halted = 1'b1;
                default: ;
            endcase
            ip = nxt;
        end
    end
    r_tos   = (n > 0) ? stk[n-1] : '0;  // empty stack shows 0
    r_depth = `FORTH_DEPTH_W'(n);
    r_steps = steps;  // opcodes retired, faulting one included
endfunction

//--- testbench/tb_forth_core.sv
// forth core testbench
// clock, reset, lcg programs, result compare, watchdog and summary
`timescale 1ns/1ps
`default_nettype none
`include "forth_config.svh"

module tb_forth_core;
    import forth_pkg::*;

    logic                      clk;
    logic                      rst;
    logic                      prog_we;
    logic [`FORTH_AW-1:0]      prog_addr;
    logic [7:0]                prog_data;
    logic                      start;
    logic [`FORTH_DW-1:0]      tos;
    logic [`FORTH_DEPTH_W-1:0] depth;
    logic                      busy;
    logic                      done;
    logic                      fault;

    // expected outcome of the program in flight
    logic [`FORTH_DW-1:0]      exp_tos;
    logic [`FORTH_DEPTH_W-1:0] exp_depth;
    logic                      exp_fault;
    int                        exp_steps;  // one busy cycle per opcode

    logic [31:0] lcg_state   = 32'hb46c;
    int          errors      = 0;
    int          checks      = 0;
    int          results     = 0;  // done pulses compared
    int          cycles      = 0;
    int          total_len   = 0;  // bytes loaded, sets the limit
    int          tests       = 0;
    int          busy_cycles = 0;  // busy cycles of the current run

    `include "tb_forth_model.svh"

    forth_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns
    end

    // watchdog, budget grows with each program
    always @(posedge clk) begin
        cycles++;
        if (cycles > 4 * total_len + 200) begin
            $display("timeout: core gave no done within %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // compare at the falling edge while done is high
    always @(negedge clk) begin
        if (!rst && busy === 1'b1) begin
            busy_cycles++;
        end
        if (!rst && done === 1'b1) begin
            check_word(tos, exp_tos, "tos");
            check_depth(depth, exp_depth);
            check_flag(fault, exp_fault, "fault");
            check_flag(busy, 1'b0, "busy at done");
            compare_run_length(busy_cycles, exp_steps);  // a restart would run longer
            busy_cycles = 0;
            results++;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(logic [`FORTH_DW-1:0] got, logic [`FORTH_DW-1:0] want,
                              string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_depth(logic [`FORTH_DEPTH_W-1:0] got,
                               logic [`FORTH_DEPTH_W-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: depth is %0d, expected %0d", $time, got, want);
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic compare_run_length(int got, int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("[FAIL] %0t: run took %0d busy cycles, expected %0d", $time, got, want);
        end
    endtask

    // load prog[], pulse start, wait for the compare
    task automatic run_program(bit poke_busy);
        int seen;
        int i;
        seen = results;
        total_len += prog_len;
        ref_run(exp_tos, exp_depth, exp_fault, exp_steps);
        for (i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = `FORTH_AW'(i);
            prog_data = prog[i];
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        start   = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (poke_busy) begin
            repeat (2) @(posedge clk);
            #2;
            start = 1'b1;  // mid-run, should be ignored
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (results == seen) @(posedge clk);
    endtask

    task automatic end_test(string name, int errs_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    initial begin
        int          e0;
        int          i;
        logic [31:0] r;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // literals and stack words
        e0 = errors;
        new_program();
        emit_lit(7'd3);
        emit_lit(7'd7);
        emit_op(OVER);   // 3 7 3
        emit_op(SWAP);   // 3 3 7
        emit_op(DUP);
        emit_op(DROP);
        emit_lit(7'd90);
        emit_op(SWAP);   // 3 3 90 7
        emit_op(OVER);
        emit_op(HALT);
        run_program(1'b0);
        end_test("stack words", e0);

        // random operand pair, one word from add through gt
        e0 = errors;
        for (i = 0; i < 40; i++) begin
            new_program();
            r = lcg_next();
            if (r[31]) begin
                emit_lit(7'd0);
                emit_lit(r[30:24]);
                emit_op(SUB);  // negative first operand
            end else begin
                emit_lit(r[30:24]);
            end
            emit_lit(r[22:16]);
            emit_op(opcode_e'(ADD + r[15:8] % 9));
            emit_op(HALT);
            run_program(1'b0);
        end
        end_test("alu and compare", e0);

        // countdown loop, then bran over a block
        e0 = errors;
        new_program();
        emit_lit(7'd6);            // 0 counter
        emit_lit(7'd1);            // 1 loop head
        emit_op(SUB);
        emit_op(DUP);
        emit_branch(ZBRAN, 8'd8);  // 4 out at zero
        emit_branch(BRAN, 8'd1);   // 6
        emit_op(HALT);             // 8
        run_program(1'b0);
        new_program();
        emit_lit(7'd40);
        emit_branch(BRAN, 8'd6);   // 1
        emit_lit(7'd99);           // 3 skipped block
        emit_lit(7'd98);
        emit_op(ADD);
        emit_lit(7'd2);            // 6
        emit_op(ADD);
        emit_op(HALT);
        run_program(1'b0);
        end_test("branches", e0);

        // underflow, then overflow at the 18th literal
        e0 = errors;
        new_program();
        emit_lit(7'd5);
        emit_op(ADD);
        emit_op(HALT);
        run_program(1'b0);
        new_program();
        for (i = 0; i < 18; i++) begin
            emit_lit(7'(i + 1));
        end
        emit_op(HALT);
        run_program(1'b0);
        end_test("faults", e0);

        // restart after fault, then start while busy
        e0 = errors;
        new_program();
        emit_lit(7'd100);
        emit_lit(7'd27);
        emit_op(SUB);
        emit_op(DUP);
        emit_op(ADD);
        emit_op(HALT);
        run_program(1'b0);
        run_program(1'b1);
        end_test("restart", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- forth_core.f
+incdir+hw
+incdir+testbench
hw/forth_pkg.sv
hw/stack_if.sv
hw/fetch_if.sv
hw/fetch_unit.sv
hw/data_stack.sv
hw/exec_unit.sv
hw/forth_core.sv
testbench/tb_forth_core.sv

//--- Bender.yml
package:
  name: forth_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/forth_pkg.sv
      - hw/stack_if.sv
      - hw/fetch_if.sv
      - hw/fetch_unit.sv
      - hw/data_stack.sv
      - hw/exec_unit.sv
      - hw/forth_core.sv

  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_forth_core.sv
